// File: bus_fabric.sv
`timescale 1ns/100ps

module bus_fabric import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       bus_req,
  input  logic       bus_we,
  input  addr_t      bus_addr,
  input  byte_mask_t bus_wmask,
  input  word_t      bus_wdata,
  input  word_t      mem_rdata,
  input  word_t      spi_rdata,
  input  word_t      gpio_rdata,
  output word_t      bus_rdata,
  output logic       bus_rvalid,
  output logic       mem_req,
  output logic       spi_req,
  output logic       gpio_req,
  output logic       reg_we,
  output logic [1:0] reg_offset,
  output addr_t      mem_index,
  output byte_mask_t wmask,
  output word_t      wdata
);

  region_t region;
  region_t rd_region_q;
  logic    rd_valid_q;

  assign region     = region_t'(bus_addr[15:14]);
  assign mem_req    = bus_req && (region == REGION_MEM);
  assign spi_req    = bus_req && (region == REGION_SPI);
  assign gpio_req   = bus_req && (region == REGION_GPIO);
  assign reg_we     = bus_we;
  assign reg_offset = bus_addr[3:2];
  assign mem_index  = {4'h0, bus_addr[13:2]};
  assign wmask      = bus_wmask;
  assign wdata      = bus_wdata;

  // Remember where the read went so the returning word can be picked
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_q  <= 1'b0;
      rd_region_q <= REGION_NONE;
    end else begin
      rd_valid_q  <= bus_req && !bus_we;
      rd_region_q <= region;
    end
  end

  assign bus_rvalid = rd_valid_q;

  always_comb begin
    case (rd_region_q)
      REGION_MEM:  bus_rdata = mem_rdata;
      REGION_SPI:  bus_rdata = spi_rdata;
      REGION_GPIO: bus_rdata = gpio_rdata;
      default:     bus_rdata = '0;
    endcase
  end

endmodule

// File: byte_lane_mem.sv
`timescale 1ns/100ps

module byte_lane_mem import soc_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic       clk,
  input  logic       mem_req,
  input  logic       reg_we,
  input  addr_t      mem_index,
  input  byte_mask_t wmask,
  input  word_t      wdata,
  output word_t      mem_rdata
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // One array per byte lane, lane_0 holds bits 7:0
  logic [7:0] lane_0 [MEM_WORDS];
  logic [7:0] lane_1 [MEM_WORDS];
  logic [7:0] lane_2 [MEM_WORDS];
  logic [7:0] lane_3 [MEM_WORDS];

  logic [IDX_W-1:0] idx;

  assign idx = mem_index[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (mem_req && reg_we) begin
      if (wmask[0]) begin
        lane_0[idx] <= wdata[7:0];
      end
      if (wmask[1]) begin
        lane_1[idx] <= wdata[15:8];
      end
      if (wmask[2]) begin
        lane_2[idx] <= wdata[23:16];
      end
      if (wmask[3]) begin
        lane_3[idx] <= wdata[31:24];
      end
    end
  end

  // Read word comes back on the next cycle
  always_ff @(posedge clk) begin
    if (mem_req && !reg_we) begin
      mem_rdata <= {lane_3[idx], lane_2[idx], lane_1[idx], lane_0[idx]};
    end
  end

  // A write with no byte enabled points at a broken master
  a_write_mask: assert property (
    @(posedge clk) (mem_req && reg_we) |-> (wmask != '0)
  ) else $error("memory write with empty byte mask at index %0d", mem_index);

endmodule

// File: de10nano_soc.sv
`timescale 1ns/100ps

module de10nano_soc import soc_pkg::*; #(
  parameter int MEM_WORDS = 1024,
  parameter int CLK_DIV   = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       bus_req,
  input  logic       bus_we,
  input  addr_t      bus_addr,
  input  byte_mask_t bus_wmask,
  input  word_t      bus_wdata,
  output word_t      bus_rdata,
  output logic       bus_rvalid,
  output logic [7:0] led,
  input  logic [1:0] key,
  output logic       sd_cs,
  output logic       sck,
  output logic       mosi,
  input  logic       miso
);

  word_t      mem_rdata;
  word_t      spi_rdata;
  word_t      gpio_rdata;
  logic       mem_req;
  logic       spi_req;
  logic       gpio_req;
  logic       reg_we;
  logic [1:0] reg_offset;
  addr_t      mem_index;
  byte_mask_t wmask;
  word_t      wdata;

  bus_fabric fabric (
    .clk, .rst_n, .bus_req, .bus_we, .bus_addr, .bus_wmask, .bus_wdata,
    .mem_rdata, .spi_rdata, .gpio_rdata, .bus_rdata, .bus_rvalid,
    .mem_req, .spi_req, .gpio_req, .reg_we, .reg_offset, .mem_index,
    .wmask, .wdata
  );

  byte_lane_mem #(.MEM_WORDS(MEM_WORDS)) mem (
    .clk, .mem_req, .reg_we, .mem_index, .wmask, .wdata, .mem_rdata
  );

  // SD card on the Arduino header
  spi_master #(.CLK_DIV(CLK_DIV)) spi (
    .clk, .rst_n, .spi_req, .reg_we, .reg_offset, .wdata, .miso,
    .spi_rdata, .sd_cs, .sck, .mosi
  );

  gpio_regs gpio (
    .clk, .rst_n, .gpio_req, .reg_we, .reg_offset, .wdata, .key,
    .gpio_rdata, .led
  );

endmodule

// File: flist.f
soc_pkg.sv
byte_lane_mem.sv
spi_master.sv
gpio_regs.sv
bus_fabric.sv
de10nano_soc.sv
tb_clock_gen.sv
spi_sd_model.sv
tb.sv

// File: gpio_regs.sv
`timescale 1ns/100ps

module gpio_regs import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       gpio_req,
  input  logic       reg_we,
  input  logic [1:0] reg_offset,
  input  word_t      wdata,
  input  logic [1:0] key,
  output word_t      gpio_rdata,
  output logic [7:0] led
);

  logic [1:0] key_meta;
  logic [1:0] key_sync;
  logic [1:0] key_prev;
  logic [1:0] key_fall;
  logic [1:0] press;
  logic [1:0] press_clr;

  // Keys are active low on the board
  assign key_fall  = key_prev & ~key_sync;
  assign press_clr = (gpio_req && reg_we && (reg_offset == GPIO_PRESS)) ? wdata[1:0] : 2'b00;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_meta <= 2'b11;
      key_sync <= 2'b11;
      key_prev <= 2'b11;
      press    <= 2'b00;
      led      <= 8'h00;
    end else begin
      key_meta <= key;
      key_sync <= key_meta;
      key_prev <= key_sync;
      // A new press wins over a clear in the same cycle
      press    <= (press & ~press_clr) | key_fall;
      if (gpio_req && reg_we && (reg_offset == GPIO_LED)) begin
        led <= wdata[7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gpio_req && !reg_we) begin
      case (reg_offset)
        GPIO_LED:   gpio_rdata <= {24'h000000, led};
        GPIO_KEY:   gpio_rdata <= {30'h0, key_sync};
        GPIO_PRESS: gpio_rdata <= {30'h0, press};
        default:    gpio_rdata <= '0;
      endcase
    end
  end

endmodule

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb -f flist.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
fi
exit 1

// File: soc_pkg.sv
package soc_pkg;

  // Bus widths
  typedef logic [31:0] word_t;
  typedef logic [15:0] addr_t;
  typedef logic [3:0]  byte_mask_t;
  typedef logic [7:0]  spi_byte_t;

  // Address region from bus_addr[15:14]
  typedef enum logic [1:0] {
    REGION_MEM  = 2'd0,
    REGION_SPI  = 2'd1,
    REGION_GPIO = 2'd2,
    REGION_NONE = 2'd3
  } region_t;

  // SPI register word offsets, bus_addr[3:2]
  localparam logic [1:0] SPI_DATA   = 2'd0;
  localparam logic [1:0] SPI_STATUS = 2'd1;
  localparam logic [1:0] SPI_CTRL   = 2'd2;

  // GPIO register word offsets
  localparam logic [1:0] GPIO_LED   = 2'd0;
  localparam logic [1:0] GPIO_KEY   = 2'd1;
  localparam logic [1:0] GPIO_PRESS = 2'd2;

  // SPI shifter states
  typedef enum logic [1:0] {
    IDLE,
    SHIFT_LOW,
    SHIFT_HIGH
  } spi_state_t;

endpackage

// File: spi_master.sv
`timescale 1ns/100ps

module spi_master import soc_pkg::*; #(
  parameter int CLK_DIV = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spi_req,
  input  logic       reg_we,
  input  logic [1:0] reg_offset,
  input  word_t      wdata,
  input  logic       miso,
  output word_t      spi_rdata,
  output logic       sd_cs,
  output logic       sck,
  output logic       mosi
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

  spi_state_t       state;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  spi_byte_t        tx_shift;
  spi_byte_t        rx_shift;
  logic             busy;
  logic             start;
  logic             half_done;

  assign busy      = (state != IDLE);
  assign start     = spi_req && reg_we && (reg_offset == SPI_DATA) && !busy;
  assign half_done = (div_cnt == DIV_LAST);

  // Mode 0, MSB first
  assign mosi = tx_shift[7];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      tx_shift <= '0;
      rx_shift <= '0;
      sck      <= 1'b0;
      sd_cs    <= 1'b1;
    end else begin
      if (spi_req && reg_we && (reg_offset == SPI_CTRL)) begin
        sd_cs <= wdata[0];
      end
      case (state)
        IDLE: begin
          // Writes while busy never reach here
          if (start) begin
            tx_shift <= wdata[7:0];
            div_cnt  <= '0;
            bit_cnt  <= '0;
            state    <= SHIFT_LOW;
          end
        end
        SHIFT_LOW: begin
          if (half_done) begin
            div_cnt  <= '0;
            sck      <= 1'b1;
            rx_shift <= {rx_shift[6:0], miso};
            state    <= SHIFT_HIGH;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        SHIFT_HIGH: begin
          if (half_done) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            // Falling edge, next bit onto mosi
            if (bit_cnt == 3'd7) begin
              state <= IDLE;
            end else begin
              bit_cnt  <= bit_cnt + 1'b1;
              tx_shift <= {tx_shift[6:0], 1'b0};
              state    <= SHIFT_LOW;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (spi_req && !reg_we) begin
      case (reg_offset)
        SPI_DATA:   spi_rdata <= {24'h000000, rx_shift};
        SPI_STATUS: spi_rdata <= {31'h0, busy};
        SPI_CTRL:   spi_rdata <= {31'h0, sd_cs};
        default:    spi_rdata <= '0;
      endcase
    end
  end

  a_sck_idle_low: assert property (
    @(posedge clk) disable iff (!rst_n) (state == IDLE) |-> !sck
  ) else $error("sck high outside a transfer");

endmodule

// File: spi_sd_model.sv
`timescale 1ns/100ps

module spi_sd_model (
  input  logic sd_cs,
  input  logic sck,
  input  logic mosi,
  output logic miso
);

  logic [7:0] rx_byte  = 8'h00;
  logic [7:0] tx_byte  = 8'hff;
  logic       sck_prev = 1'b0;
  int         bit_cnt  = 0;

  // Response goes out MSB first, already valid before the first rising edge
  assign miso = tx_byte[7];

  always @(sck or sd_cs) begin
    if (sd_cs === 1'b1) begin
      // Deselected, so the next byte after selection answers 8'hff
      bit_cnt = 0;
      tx_byte = 8'hff;
    end else if (sck === 1'b1 && sck_prev === 1'b0) begin
      rx_byte = {rx_byte[6:0], mosi};
      bit_cnt = bit_cnt + 1;
    end else if (sck === 1'b0 && sck_prev === 1'b1) begin
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        tx_byte = ~rx_byte;
      end else begin
        tx_byte = {tx_byte[6:0], 1'b1};
      end
    end
    sck_prev = sck;
  end

endmodule

// File: tb.sv
`timescale 1ns/100ps

module tb import soc_pkg::*; ();

  localparam int          MEM_WORDS    = 1024;
  localparam int          CLK_DIV      = 4;
  localparam logic [31:0] LFSR_SEED    = 32'h7c52b03e;
  localparam int          MEM_TESTS    = 16;
  localparam int          SPI_BYTES    = 4;
  localparam int          LED_TESTS    = 8;
  localparam int          SYNC_SETTLE  = 3;
  localparam int          POLL_LIMIT   = 16 * CLK_DIV;
  // Bus traffic per test, roughly two cycles per access
  localparam int          BUS_CYCLES   = 10 + 8 + 6 * MEM_TESTS + 4 + 8 * SPI_BYTES + 8
                                         + 5 * LED_TESTS + 30;
  localparam int          TEST_CYCLES  = SPI_BYTES * 16 * CLK_DIV + BUS_CYCLES;
  localparam int          WATCHDOG_CYCLES = TEST_CYCLES + 2 * TEST_CYCLES;

  localparam addr_t SPI_DATA_ADDR   = {REGION_SPI, 10'h000, SPI_DATA, 2'b00};
  localparam addr_t SPI_STATUS_ADDR = {REGION_SPI, 10'h000, SPI_STATUS, 2'b00};
  localparam addr_t SPI_CTRL_ADDR   = {REGION_SPI, 10'h000, SPI_CTRL, 2'b00};
  localparam addr_t GPIO_LED_ADDR   = {REGION_GPIO, 10'h000, GPIO_LED, 2'b00};
  localparam addr_t GPIO_KEY_ADDR   = {REGION_GPIO, 10'h000, GPIO_KEY, 2'b00};
  localparam addr_t GPIO_PRESS_ADDR = {REGION_GPIO, 10'h000, GPIO_PRESS, 2'b00};
  localparam addr_t NONE_ADDR       = {REGION_NONE, 14'h0040};

  logic       clk;
  logic       rst_n;
  logic       bus_req;
  logic       bus_we;
  addr_t      bus_addr;
  byte_mask_t bus_wmask;
  word_t      bus_wdata;
  word_t      bus_rdata;
  logic       bus_rvalid;
  logic [7:0] led;
  logic [1:0] key;
  logic       sd_cs;
  logic       sck;
  logic       mosi;
  logic       miso;

  logic [31:0] lfsr_state = LFSR_SEED;
  string       test_name;
  int          test_count;
  int          check_count;
  int          error_count;
  int          errors_at_start;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(10)) clock_gen (.clk(clk), .rst_n(rst_n));

  de10nano_soc #(.MEM_WORDS(MEM_WORDS), .CLK_DIV(CLK_DIV)) de10nano_soc_inst (
    .clk(clk), .rst_n(rst_n), .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
    .bus_wmask(bus_wmask), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
    .bus_rvalid(bus_rvalid), .led(led), .key(key), .sd_cs(sd_cs), .sck(sck),
    .mosi(mosi), .miso(miso)
  );

  spi_sd_model sd_card (.sd_cs(sd_cs), .sck(sck), .mosi(mosi), .miso(miso));

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic word_t random_bits(input int count);
    word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic check_value(input word_t expected, input word_t actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Error %s: expected %h, actual %h", test_name, expected, actual);
      error_count++;
    end
  endtask

  task automatic bus_write(input addr_t addr, input byte_mask_t mask, input word_t data);
    @(posedge clk);
    bus_req   <= 1'b1;
    bus_we    <= 1'b1;
    bus_addr  <= addr;
    bus_wmask <= mask;
    bus_wdata <= data;
    @(posedge clk);
    bus_req <= 1'b0;
    bus_we  <= 1'b0;
  endtask

  task automatic bus_read(input addr_t addr, output word_t data);
    @(posedge clk);
    bus_req  <= 1'b1;
    bus_we   <= 1'b0;
    bus_addr <= addr;
    @(negedge clk);
    check_count++;
    assert (bus_rvalid === 1'b0) else begin
      $display("Read valid came too early for address %h in %s", addr, test_name);
      error_count++;
    end
    @(posedge clk);
    bus_req <= 1'b0;
    @(negedge clk);
    check_count++;
    assert (bus_rvalid === 1'b1) else begin
      $display("No read valid one cycle after the read of %h in %s", addr, test_name);
      error_count++;
    end
    data = bus_rdata;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic end_test();
    $display("Test %s finished with %0d errors", test_name, error_count - errors_at_start);
  endtask

  task automatic test_reset_state();
    word_t rdata;
    start_test("reset_state");
    @(negedge clk);
    check_value(32'h0, {24'h0, led});
    check_value(32'h1, {31'h0, sd_cs});
    check_value(32'h0, {31'h0, sck});
    check_value(32'h0, {31'h0, mosi});
    check_value(32'h0, {31'h0, bus_rvalid});
    bus_read(SPI_STATUS_ADDR, rdata);
    check_value(32'h0, rdata);
    bus_read(GPIO_PRESS_ADDR, rdata);
    check_value(32'h0, rdata);
    end_test();
  endtask

  task automatic test_memory();
    word_t      mem_model [logic [9:0]];
    logic [9:0] idx_list [$];
    logic [9:0] idx;
    word_t      data;
    word_t      rdata;
    byte_mask_t mask;
    start_test("memory");
    for (int i = 0; i < MEM_TESTS; i++) begin
      idx  = 10'(random_bits(10));
      data = random_bits(32);
      bus_write({REGION_MEM, 2'b00, idx, 2'b00}, 4'hf, data);
      mem_model[idx] = data;
      idx_list.push_back(idx);
    end
    foreach (idx_list[i]) begin
      idx  = idx_list[i];
      mask = byte_mask_t'(random_bits(4));
      // The memory rejects an empty mask
      if (mask == 4'h0) begin
        mask = 4'h1;
      end
      data = random_bits(32);
      bus_write({REGION_MEM, 2'b00, idx, 2'b00}, mask, data);
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          mem_model[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    foreach (idx_list[i]) begin
      idx = idx_list[i];
      bus_read({REGION_MEM, 2'b00, idx, 2'b00}, rdata);
      check_value(mem_model[idx], rdata);
    end
    bus_read(NONE_ADDR, rdata);
    check_value(32'h0, rdata);
    end_test();
  endtask

  task automatic wait_spi_idle();
    word_t rdata;
    int    polls;
    polls = 0;
    do begin
      bus_read(SPI_STATUS_ADDR, rdata);
      polls++;
    end while (rdata[0] && polls < POLL_LIMIT);
    check_count++;
    assert (rdata[0] === 1'b0) else begin
      $display("SPI still busy after %0d status polls in %s", polls, test_name);
      error_count++;
    end
  endtask

  task automatic test_spi();
    spi_byte_t tx;
    spi_byte_t junk;
    spi_byte_t expected;
    word_t     rdata;
    start_test("spi");
    bus_write(SPI_CTRL_ADDR, 4'hf, 32'h0);
    @(negedge clk);
    check_value(32'h0, {31'h0, sd_cs});
    expected = 8'hff;
    for (int k = 0; k < SPI_BYTES; k++) begin
      tx = spi_byte_t'(random_bits(8));
      bus_write(SPI_DATA_ADDR, 4'hf, {24'h0, tx});
      if (k == 1) begin
        // Lands while the byte above is still shifting
        junk = spi_byte_t'(random_bits(8));
        bus_write(SPI_DATA_ADDR, 4'hf, {24'h0, junk});
      end
      wait_spi_idle();
      bus_read(SPI_DATA_ADDR, rdata);
      check_value({24'h0, expected}, rdata);
      expected = ~tx;
    end
    bus_write(SPI_CTRL_ADDR, 4'hf, 32'h1);
    @(negedge clk);
    check_value(32'h1, {31'h0, sd_cs});
    end_test();
  endtask

  task automatic test_led();
    logic [7:0] value;
    word_t      rdata;
    start_test("led");
    for (int i = 0; i < LED_TESTS; i++) begin
      value = 8'(random_bits(8));
      bus_write(GPIO_LED_ADDR, 4'hf, {24'h0, value});
      @(negedge clk);
      check_value({24'h0, value}, {24'h0, led});
      bus_read(GPIO_LED_ADDR, rdata);
      check_value({24'h0, value}, rdata);
    end
    end_test();
  endtask

  task automatic test_keys();
    word_t rdata;
    start_test("keys");
    @(posedge clk);
    key <= 2'b01;
    repeat (SYNC_SETTLE) @(posedge clk);
    bus_read(GPIO_KEY_ADDR, rdata);
    check_value(32'h1, rdata);
    @(posedge clk);
    key <= 2'b11;
    repeat (SYNC_SETTLE) @(posedge clk);
    bus_read(GPIO_KEY_ADDR, rdata);
    check_value(32'h3, rdata);
    bus_read(GPIO_PRESS_ADDR, rdata);
    check_value(32'h2, rdata);
    bus_write(GPIO_PRESS_ADDR, 4'hf, 32'h2);
    bus_read(GPIO_PRESS_ADDR, rdata);
    check_value(32'h0, rdata);
    end_test();
  endtask

  initial begin
    bus_req   <= 1'b0;
    bus_we    <= 1'b0;
    bus_addr  <= '0;
    bus_wmask <= '0;
    bus_wdata <= '0;
    key       <= 2'b11;
    test_count  = 0;
    check_count = 0;
    error_count = 0;
    wait (rst_n === 1'b1);
    test_reset_state();
    test_memory();
    test_spi();
    test_led();
    test_keys();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

  initial begin
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule
